// ==== common/axi_lite_pkg.sv ====
package axi_lite_pkg;

  localparam int AXI_ADDR_W = 5;
  localparam int AXI_DATA_W = 32;
  localparam int AXI_ID_W   = 4;
  localparam int AXI_STRB_W = AXI_DATA_W / 8;
  localparam int AXI_LSB    = 2;                // byte offset bits dropped on decode

  localparam logic [1:0] RESP_OKAY = 2'b00;

  typedef struct packed {
    logic [AXI_ID_W-1:0]   id;
    logic [AXI_ADDR_W-1:0] addr;
  } axi_ar_t;

  typedef struct packed {
    logic [AXI_ID_W-1:0]   id;
    logic [AXI_ADDR_W-1:0] addr;
  } axi_aw_t;

  typedef struct packed {
    logic [AXI_DATA_W-1:0] data;
    logic [AXI_STRB_W-1:0] strb;
  } axi_w_t;

  typedef struct packed {
    logic [AXI_ID_W-1:0]   id;
    logic [AXI_DATA_W-1:0] data;
    logic [1:0]            resp;
  } axi_r_t;

  typedef struct packed {
    logic [AXI_ID_W-1:0] id;
    logic [1:0]          resp;
  } axi_b_t;

endpackage

// ==== common/uart_regs_pkg.sv ====
package uart_regs_pkg;

  // word indices, address bits [4:2]
  localparam logic [2:0] REG_DATA = 3'd0;   // rbr on read, thr on write
  localparam logic [2:0] REG_IER  = 3'd1;
  localparam logic [2:0] REG_LCR  = 3'd3;
  localparam logic [2:0] REG_LSR  = 3'd5;
  localparam logic [2:0] REG_DIV  = 3'd7;   // baud divisor, dlab only

  localparam int LCR_DLAB = 7;

  localparam int LSR_DR   = 0;
  localparam int LSR_THRE = 5;              // tx fifo not full
  localparam int LSR_TEMT = 6;              // tx fifo and shifter empty

  localparam logic [7:0] LSR_RESET = 8'h60;

  localparam int DIV_W = 16;

  typedef logic [7:0] uart_byte_t;

  typedef struct packed {
    logic full;
    logic empty;
  } fifo_status_t;

endpackage

// ==== hdl/byte_fifo.sv ====
`timescale 1ns/1ns

module byte_fifo #(
  parameter int unsigned DEPTH = 16
) (
  input  logic                       axi_aclk_i,
  input  logic                       axi_aresetn_i,
  input  logic                       push_i,
  input  uart_regs_pkg::uart_byte_t  data_i,
  input  logic                       pull_i,
  output uart_regs_pkg::uart_byte_t  data_o,
  output uart_regs_pkg::fifo_status_t status_o
);
  import uart_regs_pkg::*;

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  uart_byte_t       mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr, rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push, do_pull;

  assign status_o.empty = (count == '0);
  assign status_o.full  = (count == CNT_W'(DEPTH));
  assign do_push = push_i & ~status_o.full;   // dropped when full
  assign do_pull = pull_i & ~status_o.empty;
  assign data_o  = mem[rd_ptr];               // head shown without a pull

  always_ff @(posedge axi_aclk_i) begin
    if (do_push) mem[wr_ptr] <= data_i;
  end

  always_ff @(posedge axi_aclk_i or negedge axi_aresetn_i) begin
    if (!axi_aresetn_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pull) rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({do_push, do_pull})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // the consumer must check status before pulling
  a_no_pull_empty: assert property (@(posedge axi_aclk_i) disable iff (!axi_aresetn_i)
    pull_i |-> !status_o.empty);

  a_count_bound: assert property (@(posedge axi_aclk_i) disable iff (!axi_aresetn_i)
    count <= CNT_W'(DEPTH));

endmodule

// ==== hdl/axi_read_port.sv ====
`timescale 1ns/1ns

module axi_read_port (
  input  logic                        axi_aclk_i,
  input  logic                        axi_aresetn_i,
  input  axi_lite_pkg::axi_ar_t       ar_i,
  input  logic                        ar_valid_i,
  output logic                        ar_ready_o,
  output axi_lite_pkg::axi_r_t        r_o,
  output logic                        r_valid_o,
  input  logic                        r_ready_i,
  input  uart_regs_pkg::uart_byte_t   rx_head_i,
  input  uart_regs_pkg::fifo_status_t rx_status_i,
  output logic                        rx_pull_o,
  input  uart_regs_pkg::fifo_status_t tx_status_i,
  input  logic                        tx_busy_i,
  input  logic                        dlab_i,
  input  logic                        irq_en_i,
  output logic                        read_irq_o
);
  import axi_lite_pkg::*;
  import uart_regs_pkg::*;

  typedef enum logic [1:0] {RD_INIT, RD_IDLE, RD_RESP} rd_state_e;

  rd_state_e             state_q;
  logic                  ar_hs;
  logic [2:0]            ar_idx;
  logic [AXI_DATA_W-1:0] rdata;
  logic [AXI_ID_W-1:0]   rid_q;
  logic [AXI_DATA_W-1:0] rdata_q;
  logic [7:0]            lsr_q;

  assign ar_ready_o = (state_q == RD_IDLE);
  assign r_valid_o  = (state_q == RD_RESP);
  assign ar_hs      = ar_ready_o & ar_valid_i;
  assign ar_idx     = ar_i.addr[AXI_ADDR_W-1:AXI_LSB];

  // pop on the acceptance edge, head is captured the same edge
  assign rx_pull_o = ar_hs & (ar_idx == REG_DATA) & ~dlab_i & ~rx_status_i.empty;

  always_comb begin
    rdata = '0;
    case (ar_idx)
      REG_DATA: if (!dlab_i && !rx_status_i.empty) rdata = {{(AXI_DATA_W-8){1'b0}}, rx_head_i};
      REG_LSR:  rdata = {{(AXI_DATA_W-8){1'b0}}, lsr_q};
      default:  rdata = '0;                  // unmapped reads as zero
    endcase
  end

  always_ff @(posedge axi_aclk_i or negedge axi_aresetn_i) begin
    if (!axi_aresetn_i) begin
      state_q <= RD_INIT;
    end else begin
      case (state_q)
        RD_INIT: state_q <= RD_IDLE;         // ready one clock after reset
        RD_IDLE: if (ar_hs) state_q <= RD_RESP;
        RD_RESP: if (r_ready_i) state_q <= RD_IDLE;
        default: state_q <= RD_INIT;
      endcase
    end
  end

  always_ff @(posedge axi_aclk_i) begin
    if (ar_hs) begin
      rid_q   <= ar_i.id;
      rdata_q <= rdata;
    end
  end

  assign r_o.id   = rid_q;
  assign r_o.data = rdata_q;
  assign r_o.resp = RESP_OKAY;

  always_ff @(posedge axi_aclk_i or negedge axi_aresetn_i) begin
    if (!axi_aresetn_i) begin
      lsr_q      <= LSR_RESET;
      read_irq_o <= 1'b0;
    end else begin
      lsr_q           <= '0;
      lsr_q[LSR_DR]   <= ~rx_status_i.empty;
      lsr_q[LSR_THRE] <= ~tx_status_i.full;
      lsr_q[LSR_TEMT] <= tx_status_i.empty & ~tx_busy_i;
      read_irq_o      <= ~rx_status_i.empty & irq_en_i;   // level irq
    end
  end

  a_r_stable: assert property (@(posedge axi_aclk_i) disable iff (!axi_aresetn_i)
    r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_o));

endmodule

// ==== hdl/axi_write_port.sv ====
`timescale 1ns/1ns

module axi_write_port #(
  parameter int unsigned DIV_RESET = 434
) (
  input  logic                                  axi_aclk_i,
  input  logic                                  axi_aresetn_i,
  input  axi_lite_pkg::axi_aw_t                 aw_i,
  input  logic                                  aw_valid_i,
  output logic                                  aw_ready_o,
  input  axi_lite_pkg::axi_w_t                  w_i,
  input  logic                                  w_valid_i,
  output logic                                  w_ready_o,
  output axi_lite_pkg::axi_b_t                  b_o,
  output logic                                  b_valid_o,
  input  logic                                  b_ready_i,
  output logic                                  tx_push_o,
  output uart_regs_pkg::uart_byte_t             tx_byte_o,
  output logic                                  dlab_o,
  output logic                                  irq_en_o,
  output logic [uart_regs_pkg::DIV_W-1:0]       divisor_o
);
  import axi_lite_pkg::*;
  import uart_regs_pkg::*;

  typedef enum logic {WR_IDLE, WR_RESP} wr_state_e;

  wr_state_e           state_q;
  logic                ready_q;
  logic                wr_hs;
  logic [2:0]          aw_idx;
  logic [AXI_ID_W-1:0] bid_q;
  logic                dlab_q;
  logic                irq_en_q;
  logic [DIV_W-1:0]    divisor_q;

  assign aw_ready_o = ready_q;
  assign w_ready_o  = ready_q;
  assign b_valid_o  = (state_q == WR_RESP);
  assign wr_hs      = ready_q & aw_valid_i & w_valid_i;   // aw and w taken together
  assign aw_idx     = aw_i.addr[AXI_ADDR_W-1:AXI_LSB];

  // thr write, a full fifo drops the byte itself
  assign tx_push_o = wr_hs & (aw_idx == REG_DATA) & ~dlab_q;
  assign tx_byte_o = w_i.data[7:0];

  always_ff @(posedge axi_aclk_i or negedge axi_aresetn_i) begin
    if (!axi_aresetn_i) begin
      state_q <= WR_IDLE;
      ready_q <= 1'b0;
    end else begin
      case (state_q)
        WR_IDLE: begin
          if (wr_hs) begin
            state_q <= WR_RESP;
            ready_q <= 1'b0;
          end else begin
            ready_q <= 1'b1;                 // also the first clock after reset
          end
        end
        WR_RESP: begin
          if (b_ready_i) begin
            state_q <= WR_IDLE;
            ready_q <= 1'b1;
          end
        end
        default: state_q <= WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge axi_aclk_i or negedge axi_aresetn_i) begin
    if (!axi_aresetn_i) begin
      dlab_q    <= 1'b0;
      irq_en_q  <= 1'b0;
      divisor_q <= DIV_W'(DIV_RESET);
    end else if (wr_hs) begin
      case (aw_idx)
        REG_IER: irq_en_q <= w_i.data[0];
        REG_LCR: dlab_q   <= w_i.data[LCR_DLAB];
        REG_DIV: if (dlab_q) divisor_q <= w_i.data[DIV_W-1:0];
        default: ;                           // thr handled by push, rest ignored
      endcase
    end
  end

  always_ff @(posedge axi_aclk_i) begin
    if (wr_hs) bid_q <= aw_i.id;
  end

  assign b_o.id    = bid_q;
  assign b_o.resp  = RESP_OKAY;
  assign dlab_o    = dlab_q;
  assign irq_en_o  = irq_en_q;
  assign divisor_o = divisor_q;

  a_b_hold: assert property (@(posedge axi_aclk_i) disable iff (!axi_aresetn_i)
    b_valid_o && !b_ready_i |=> b_valid_o && $stable(b_o));

endmodule

// ==== uart_serial/uart_tx.sv ====
`timescale 1ns/1ns

module uart_tx (
  input  logic                            axi_aclk_i,
  input  logic                            axi_aresetn_i,
  input  logic [uart_regs_pkg::DIV_W-1:0] divisor_i,
  input  uart_regs_pkg::uart_byte_t       tx_data_i,
  input  uart_regs_pkg::fifo_status_t     tx_status_i,
  output logic                            tx_pull_o,
  output logic                            tx_busy_o,
  output logic                            uart_tx_o
);
  import uart_regs_pkg::*;

  typedef enum logic {TX_IDLE, TX_SHIFT} tx_state_e;

  tx_state_e        state_q;
  logic [DIV_W-1:0] baud_cnt;
  logic [3:0]       bit_cnt;                 // 0 start, 1..8 data, 9 stop
  logic [8:0]       frame_q;                 // stop bit on top, data below
  logic             line_q;
  logic             bit_end;

  assign tx_busy_o = (state_q == TX_SHIFT);
  assign tx_pull_o = (state_q == TX_IDLE) & ~tx_status_i.empty;
  assign bit_end   = tx_busy_o & (baud_cnt == divisor_i - 1'b1);
  assign uart_tx_o = line_q;

  always_ff @(posedge axi_aclk_i or negedge axi_aresetn_i) begin
    if (!axi_aresetn_i) begin
      state_q  <= TX_IDLE;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      line_q   <= 1'b1;                      // line idles high
    end else begin
      case (state_q)
        TX_IDLE: begin
          if (tx_pull_o) begin
            state_q  <= TX_SHIFT;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            line_q   <= 1'b0;                // start bit
          end
        end
        TX_SHIFT: begin
          if (bit_end) begin
            baud_cnt <= '0;
            if (bit_cnt == 4'd9) begin
              state_q <= TX_IDLE;
            end else begin
              bit_cnt <= bit_cnt + 1'b1;
              line_q  <= frame_q[0];         // lsb first
            end
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        default: state_q <= TX_IDLE;
      endcase
    end
  end

  always_ff @(posedge axi_aclk_i) begin
    if (tx_pull_o) frame_q <= {1'b1, tx_data_i};
    else if (bit_end) frame_q <= {1'b1, frame_q[8:1]};
  end

endmodule

// ==== uart_serial/uart_rx.sv ====
`timescale 1ns/1ns

module uart_rx (
  input  logic                            axi_aclk_i,
  input  logic                            axi_aresetn_i,
  input  logic [uart_regs_pkg::DIV_W-1:0] divisor_i,
  input  logic                            uart_rx_i,
  output logic                            rx_push_o,
  output uart_regs_pkg::uart_byte_t       rx_data_o
);
  import uart_regs_pkg::*;

  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

  rx_state_e        state_q;
  logic             rx_meta, rx_sync, rx_prev;
  logic [DIV_W-1:0] baud_cnt;
  logic [2:0]       bit_cnt;
  uart_byte_t       shift_q;
  logic             half_tick, full_tick;

  assign half_tick = (baud_cnt == {1'b0, divisor_i[DIV_W-1:1]});
  assign full_tick = (baud_cnt == divisor_i - 1'b1);
  assign rx_push_o = (state_q == RX_STOP) & full_tick;   // middle of stop bit
  assign rx_data_o = shift_q;

  // two-flop synchronizer plus one stage for edge detect
  always_ff @(posedge axi_aclk_i or negedge axi_aresetn_i) begin
    if (!axi_aresetn_i) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= uart_rx_i;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge axi_aclk_i or negedge axi_aresetn_i) begin
    if (!axi_aresetn_i) begin
      state_q  <= RX_IDLE;
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end else begin
      case (state_q)
        RX_IDLE: begin
          baud_cnt <= '0;
          if (rx_prev && !rx_sync) state_q <= RX_START;   // falling edge
        end
        RX_START: begin
          if (half_tick) begin
            baud_cnt <= '0;
            bit_cnt  <= '0;
            state_q  <= rx_sync ? RX_IDLE : RX_DATA;      // high here is a glitch
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        RX_DATA: begin
          if (full_tick) begin
            baud_cnt <= '0;
            bit_cnt  <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) state_q <= RX_STOP;
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        RX_STOP: begin
          if (full_tick) begin
            baud_cnt <= '0;
            state_q  <= RX_IDLE;             // byte kept even if stop is low
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        default: state_q <= RX_IDLE;
      endcase
    end
  end

  always_ff @(posedge axi_aclk_i) begin
    if ((state_q == RX_DATA) && full_tick) shift_q <= {rx_sync, shift_q[7:1]};
  end

endmodule

// ==== hdl/axi_uart_top.sv ====
`timescale 1ns/1ns

module axi_uart_top #(
  parameter int unsigned FIFO_DEPTH = 16,
  parameter int unsigned DIV_RESET  = 434
) (
  input  logic                  axi_aclk_i,
  input  logic                  axi_aresetn_i,
  input  axi_lite_pkg::axi_ar_t ar_i,
  input  logic                  ar_valid_i,
  output logic                  ar_ready_o,
  output axi_lite_pkg::axi_r_t  r_o,
  output logic                  r_valid_o,
  input  logic                  r_ready_i,
  input  axi_lite_pkg::axi_aw_t aw_i,
  input  logic                  aw_valid_i,
  output logic                  aw_ready_o,
  input  axi_lite_pkg::axi_w_t  w_i,
  input  logic                  w_valid_i,
  output logic                  w_ready_o,
  output axi_lite_pkg::axi_b_t  b_o,
  output logic                  b_valid_o,
  input  logic                  b_ready_i,
  input  logic                  uart_rx_i,
  output logic                  uart_tx_o,
  output logic                  read_irq_o
);
  import uart_regs_pkg::*;

  logic             tx_push, tx_pull, tx_busy;
  uart_byte_t       tx_byte, tx_head;
  fifo_status_t     tx_status;
  logic             rx_push, rx_pull;
  uart_byte_t       rx_byte, rx_head;
  fifo_status_t     rx_status;
  logic             dlab, irq_en;
  logic [DIV_W-1:0] divisor;

  axi_read_port u_read_port (
    .axi_aclk_i, .axi_aresetn_i,
    .ar_i, .ar_valid_i, .ar_ready_o,
    .r_o, .r_valid_o, .r_ready_i,
    .rx_head_i   (rx_head),
    .rx_status_i (rx_status),
    .rx_pull_o   (rx_pull),
    .tx_status_i (tx_status),
    .tx_busy_i   (tx_busy),
    .dlab_i      (dlab),
    .irq_en_i    (irq_en),
    .read_irq_o
  );

  axi_write_port #(.DIV_RESET(DIV_RESET)) u_write_port (
    .axi_aclk_i, .axi_aresetn_i,
    .aw_i, .aw_valid_i, .aw_ready_o,
    .w_i, .w_valid_i, .w_ready_o,
    .b_o, .b_valid_o, .b_ready_i,
    .tx_push_o (tx_push),
    .tx_byte_o (tx_byte),
    .dlab_o    (dlab),
    .irq_en_o  (irq_en),
    .divisor_o (divisor)
  );

  byte_fifo #(.DEPTH(FIFO_DEPTH)) u_tx_fifo (
    .axi_aclk_i, .axi_aresetn_i,
    .push_i (tx_push), .data_i (tx_byte),
    .pull_i (tx_pull), .data_o (tx_head),
    .status_o (tx_status)
  );

  byte_fifo #(.DEPTH(FIFO_DEPTH)) u_rx_fifo (
    .axi_aclk_i, .axi_aresetn_i,
    .push_i (rx_push), .data_i (rx_byte),
    .pull_i (rx_pull), .data_o (rx_head),
    .status_o (rx_status)
  );

  uart_tx u_uart_tx (
    .axi_aclk_i, .axi_aresetn_i,
    .divisor_i   (divisor),
    .tx_data_i   (tx_head),
    .tx_status_i (tx_status),
    .tx_pull_o   (tx_pull),
    .tx_busy_o   (tx_busy),
    .uart_tx_o
  );

  uart_rx u_uart_rx (
    .axi_aclk_i, .axi_aresetn_i,
    .divisor_i (divisor),
    .uart_rx_i,
    .rx_push_o (rx_push),
    .rx_data_o (rx_byte)
  );

endmodule

// ==== bench/tb_axi_tasks.svh ====
`ifndef TB_AXI_TASKS_SVH
`define TB_AXI_TASKS_SVH

function automatic int rand_between(input int lo, input int hi);
  int r;
  r = $random(seed) & 32'h7fff_ffff;
  return lo + r % (hi - lo + 1);
endfunction

task automatic step_cycles(input int n);
  repeat (n) @(posedge axi_aclk_i);
  #1;                                      // inputs change just after the edge
endtask

task automatic report_error(input string msg);
  n_other++;
  $display("ERROR at %0t: %s", $time, msg);
endtask

task automatic check_r(input axi_r_t got, input axi_r_t exp);
  if (got !== exp) begin
    n_mismatch++;
    $display("MISMATCH at %0t: R id %h data %h resp %h, expected id %h data %h resp %h",
             $time, got.id, got.data, got.resp, exp.id, exp.data, exp.resp);
  end
endtask

task automatic check_b(input axi_b_t got, input axi_b_t exp);
  if (got !== exp) begin
    n_mismatch++;
    $display("MISMATCH at %0t: B id %h resp %h, expected id %h resp %h",
             $time, got.id, got.resp, exp.id, exp.resp);
  end
endtask

task automatic check_byte(input uart_byte_t got, input uart_byte_t exp);
  if (got !== exp) begin
    n_mismatch++;
    $display("MISMATCH at %0t: serial byte %h, expected %h", $time, got, exp);
  end
endtask

task automatic check_irq(input logic got, input logic exp);
  if (got !== exp) begin
    n_mismatch++;
    $display("MISMATCH at %0t: read_irq_o %b, expected %b", $time, got, exp);
  end
endtask

task automatic axi_read(input logic [2:0] idx, input logic [AXI_DATA_W-1:0] exp_data,
                        input logic [AXI_DATA_W-1:0] free_bits,
                        output logic [AXI_DATA_W-1:0] data);
  axi_r_t exp_r;
  int     hold;
  exp_r.id   = AXI_ID_W'(rand_between(0, 15));
  exp_r.resp = RESP_OKAY;
  ar_i.id    = exp_r.id;
  ar_i.addr  = {idx, {AXI_LSB{1'b0}}};
  ar_valid_i = 1'b1;
  while (!ar_ready_o) step_cycles(1);
  step_cycles(1);                          // address taken on this edge
  ar_valid_i = 1'b0;
  while (!r_valid_o) step_cycles(1);
  exp_r.data = (exp_data & ~free_bits) | (r_o.data & free_bits);   // free bits only held
  hold = rand_between(0, 5);
  repeat (hold) begin
    check_r(r_o, exp_r);
    step_cycles(1);
    if (!r_valid_o) report_error("read response dropped before it was taken");
  end
  check_r(r_o, exp_r);
  r_ready_i = 1'b1;
  step_cycles(1);
  r_ready_i = 1'b0;
  if (r_valid_o) report_error("read response still valid after it was taken");
  data = exp_r.data;
endtask

task automatic axi_write(input logic [2:0] idx, input logic [AXI_DATA_W-1:0] data);
  axi_b_t exp_b;
  int     hold;
  exp_b.id   = AXI_ID_W'(rand_between(0, 15));
  exp_b.resp = RESP_OKAY;
  aw_i.id    = exp_b.id;
  aw_i.addr  = {idx, {AXI_LSB{1'b0}}};
  w_i.data   = data;
  w_i.strb   = '1;
  aw_valid_i = 1'b1;
  w_valid_i  = 1'b1;
  while (!(aw_ready_o && w_ready_o)) step_cycles(1);
  step_cycles(1);                          // aw and w taken together
  aw_valid_i = 1'b0;
  w_valid_i  = 1'b0;
  while (!b_valid_o) step_cycles(1);
  hold = rand_between(0, 5);
  repeat (hold) begin
    check_b(b_o, exp_b);
    step_cycles(1);
    if (!b_valid_o) report_error("write response dropped before it was taken");
  end
  check_b(b_o, exp_b);
  b_ready_i = 1'b1;
  step_cycles(1);
  b_ready_i = 1'b0;
  if (b_valid_o) report_error("write response still valid after it was taken");
endtask

task automatic send_serial_byte(input uart_byte_t data);
  uart_rx_i = 1'b0;                        // start bit
  step_cycles(div_model);
  for (int i = 0; i < 8; i++) begin
    uart_rx_i = data[i];                   // lsb first
    step_cycles(div_model);
  end
  uart_rx_i = 1'b1;                        // stop bit and a short idle
  step_cycles(div_model + 4);
endtask

// called one negedge after the line fell, samples at mid-bit
task automatic capture_tx_frame(output uart_byte_t data, output logic framing_ok);
  int div;
  div        = div_model;
  framing_ok = 1'b1;
  repeat (div / 2) @(negedge axi_aclk_i);
  if (uart_tx_o !== 1'b0) framing_ok = 1'b0;
  for (int i = 0; i < 8; i++) begin
    repeat (div) @(negedge axi_aclk_i);
    data[i] = uart_tx_o;
  end
  repeat (div) @(negedge axi_aclk_i);
  if (uart_tx_o !== 1'b1) framing_ok = 1'b0;
endtask

`endif

// ==== bench/tb_axi_uart.sv ====
`timescale 1ns/1ns

module tb_axi_uart;
  import axi_lite_pkg::*;
  import uart_regs_pkg::*;

  localparam int FIFO_DEPTH = 4;
  localparam int DIV_RESET  = 8;
  localparam int DIV_MAX    = 12;
  localparam int N_TX       = 12;
  localparam int N_RX       = 10;
  localparam int N_GATE     = 3;
  localparam int unsigned TIMEOUT_CYCLES = (N_TX + N_RX + N_GATE) * 10 * DIV_MAX * 4 + 2000;

  logic        axi_aclk_i = 1'b0;
  logic        axi_aresetn_i;
  axi_ar_t     ar_i;
  logic        ar_valid_i, ar_ready_o;
  axi_r_t      r_o;
  logic        r_valid_o, r_ready_i;
  axi_aw_t     aw_i;
  logic        aw_valid_i, aw_ready_o;
  axi_w_t      w_i;
  logic        w_valid_i, w_ready_o;
  axi_b_t      b_o;
  logic        b_valid_o, b_ready_i;
  logic        uart_rx_i, uart_tx_o, read_irq_o;

  integer      seed = 34386;
  int          n_mismatch = 0;
  int          n_other = 0;
  int unsigned cycles = 0;
  int          div_model = DIV_RESET;
  logic        dlab_model = 1'b0;
  logic        ier_model = 1'b0;
  logic        mon_busy = 1'b0;
  uart_byte_t  tx_exp[$];                  // bytes still to appear on uart_tx_o
  uart_byte_t  rx_exp[$];                  // bytes held in the rx fifo

  `include "tb_axi_tasks.svh"

  axi_uart_top #(.FIFO_DEPTH(FIFO_DEPTH), .DIV_RESET(DIV_RESET)) dut_i (.*);

  always #2 axi_aclk_i = ~axi_aclk_i;

  always @(posedge axi_aclk_i) begin
    cycles <= cycles + 1;
    if (cycles == TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, a handshake or serial frame never completed", cycles);
      $display("TESTS FAILED");
      $finish;
    end
  end

  initial begin : tx_monitor
    uart_byte_t got;
    logic       framing_ok;
    wait (axi_aresetn_i === 1'b1);
    forever begin
      @(negedge axi_aclk_i);
      if (uart_tx_o === 1'b0) begin
        mon_busy = 1'b1;
        capture_tx_frame(got, framing_ok);
        if (!framing_ok) report_error("uart_tx_o frame had a bad start or stop bit");
        if (tx_exp.size() == 0) report_error("uart_tx_o sent a frame that was not expected");
        else check_byte(got, tx_exp.pop_front());
        mon_busy = 1'b0;
      end
    end
  end

  task automatic reg_write(input logic [2:0] idx, input logic [AXI_DATA_W-1:0] data);
    case (idx)
      REG_DATA: if (!dlab_model) tx_exp.push_back(data[7:0]);
      REG_IER:  ier_model = data[0];
      REG_LCR:  dlab_model = data[LCR_DLAB];
      REG_DIV:  if (dlab_model) div_model = int'(data[DIV_W-1:0]);
      default:  ;
    endcase
    axi_write(idx, data);
  endtask

  function automatic logic [AXI_DATA_W-1:0] expected_lsr();
    logic [AXI_DATA_W-1:0] v;
    v           = '0;
    v[LSR_DR]   = (rx_exp.size() != 0);
    v[LSR_THRE] = 1'b1;                    // tx side is idle wherever this is used
    v[LSR_TEMT] = 1'b1;
    return v;
  endfunction

  task automatic check_line_state();
    logic [AXI_DATA_W-1:0] d;
    step_cycles(3);                        // fifo status and irq register settle
    check_irq(read_irq_o, (rx_exp.size() != 0) && ier_model);
    axi_read(REG_LSR, expected_lsr(), '0, d);
  endtask

  task automatic read_rbr();
    logic [AXI_DATA_W-1:0] exp;
    logic [AXI_DATA_W-1:0] d;
    exp = '0;
    if (rx_exp.size() != 0) exp[7:0] = rx_exp.pop_front();   // empty reads as zero
    axi_read(REG_DATA, exp, '0, d);
  endtask

  task automatic send_tx_bytes(input int n);
    logic [AXI_DATA_W-1:0] d;
    logic [AXI_DATA_W-1:0] tx_bits;
    tx_bits           = '0;
    tx_bits[LSR_THRE] = 1'b1;              // these follow the serial timing
    tx_bits[LSR_TEMT] = 1'b1;
    repeat (n) begin
      d = '0;
      while (!d[LSR_THRE]) axi_read(REG_LSR, expected_lsr(), tx_bits, d);
      reg_write(REG_DATA, 32'(rand_between(0, 255)));
    end
  endtask

  task automatic wait_tx_done();
    while (tx_exp.size() != 0 || mon_busy) step_cycles(1);
    step_cycles(div_model + 3);            // rest of the stop bit
  endtask

  task automatic test_reset_decode();
    logic [AXI_DATA_W-1:0] d;
    axi_read(REG_LSR, {24'h0, LSR_RESET}, '0, d);
    axi_read(REG_IER, '0, '0, d);
    axi_read(REG_LCR, '0, '0, d);
    axi_read(REG_DIV, '0, '0, d);
    axi_read(3'd2, '0, '0, d);             // unmapped word
  endtask

  task automatic test_transmit();
    reg_write(REG_LCR, 32'h80);
    reg_write(REG_DIV, 32'(rand_between(4, DIV_MAX)));
    reg_write(REG_LCR, 32'h0);
    send_tx_bytes(N_TX);
    wait_tx_done();
    check_line_state();
  endtask

  task automatic test_receive();
    int act;
    int sent;
    sent = 0;
    while (sent < N_RX) begin
      act = rand_between(0, 3);
      if (act == 0) begin
        reg_write(REG_IER, 32'(rand_between(0, 1)));
      end else if (rx_exp.size() < FIFO_DEPTH && (act == 1 || rx_exp.size() == 0)) begin
        rx_exp.push_back(8'(rand_between(0, 255)));
        send_serial_byte(rx_exp[$]);
        sent++;
      end else begin
        read_rbr();
      end
      check_line_state();
    end
    while (rx_exp.size() != 0) begin
      read_rbr();
      check_line_state();
    end
    read_rbr();
    check_line_state();
  endtask

  task automatic test_dlab_gating();
    reg_write(REG_LCR, 32'h80);
    reg_write(REG_DATA, 32'(rand_between(0, 255)));   // no push while dlab is set
    step_cycles(12 * div_model);
    check_line_state();
    reg_write(REG_LCR, 32'h0);
    reg_write(REG_DIV, 32'(rand_between(DIV_MAX + 1, 40)));
    send_tx_bytes(N_GATE);
    wait_tx_done();
    check_line_state();
  endtask

  initial begin
    ar_i          = '0;
    ar_valid_i    = 1'b0;
    r_ready_i     = 1'b0;
    aw_i          = '0;
    aw_valid_i    = 1'b0;
    w_i           = '0;
    w_valid_i     = 1'b0;
    b_ready_i     = 1'b0;
    uart_rx_i     = 1'b1;
    axi_aresetn_i = 1'b0;
    repeat (8) @(posedge axi_aclk_i);
    if (ar_ready_o || aw_ready_o || w_ready_o || r_valid_o || b_valid_o || uart_tx_o !== 1'b1)
      report_error("outputs were not at their reset values during reset");
    check_irq(read_irq_o, 1'b0);
    #1;
    axi_aresetn_i = 1'b1;
    step_cycles(1);
    if (!(ar_ready_o === 1'b1 && aw_ready_o === 1'b1 && w_ready_o === 1'b1))
      report_error("ready outputs did not rise on the first clock after reset");
    step_cycles(1);
    test_reset_decode();
    test_transmit();
    test_receive();
    test_dlab_gating();
    $display("%0d mismatches, %0d other errors", n_mismatch, n_other);
    if (n_mismatch == 0 && n_other == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+bench
common/axi_lite_pkg.sv
common/uart_regs_pkg.sv
hdl/byte_fifo.sv
hdl/axi_read_port.sv
hdl/axi_write_port.sv
uart_serial/uart_tx.sv
uart_serial/uart_rx.sv
hdl/axi_uart_top.sv
bench/tb_axi_uart.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLIST     ?= flist.f
TOP       ?= tb_axi_uart
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, fail on a failing log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if [ $$rc -ne 0 ] || grep -q "TESTS FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
